// File: hw/lsu_defs.svh
/*
  Width and depth macros of the load/store unit
  Address, data and byte enable widths
  Outstanding bus transaction limit and counter width
*/
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_BE_W   4   // One enable per byte lane

// Outstanding transactions on the data bus
`define LSU_DEPTH  2

// Counter must hold 0 up to LSU_DEPTH
`define LSU_CNT_W  2

`endif

// File: hw/lsu_pkg.sv
/*
  Shared types of the load/store unit
  Access size enum
  WB stage control struct, captured when the EX address phase completes
*/
`default_nettype none

package lsu_pkg;

  // Access size, encoded as in funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Control fields that travel from EX to WB with each transfer
  typedef struct packed {
    lsu_size_e  size;    // Access size
    logic       sext;    // Sign extend load data
    logic       we;      // Store
    logic [1:0] offset;  // Byte offset of the original address
    logic       last;    // Clear only for first half of a split access
  } lsu_wb_ctrl_t;

endpackage

`default_nettype wire

// File: hw/lsu_obi_if.sv
/*
  Internal OBI-style data bus of the load/store unit
  Request/grant address phase and rvalid response phase
  Modports for the requester, the tracker and the receiver
*/
`default_nettype none
`timescale 1ns/1ns
`include "lsu_defs.svh"

interface lsu_obi_if;

  // Address phase
  logic                   req;
  logic                   gnt;
  logic [`LSU_ADDR_W-1:0] addr;
  logic                   we;
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata;

  // Response phase
  logic                   rvalid;
  logic [`LSU_DATA_W-1:0] rdata;

  // Address phase fields, req only watched
  modport requester (output addr, we, be, wdata, input req);
  // Request strobe and transaction counting
  modport tracker   (output req, input gnt, rvalid);
  // Load data return
  modport receiver  (input rvalid, rdata);

endinterface

`default_nettype wire

// File: hw/lsu_request_gen.sv
/*
  Request generation of the load/store unit
  Address adder, split and misaligned detection, split phase register
  Byte enables, write data rotation, bus address phase fields
  WB control fields for the transfer being issued
*/
`default_nettype none
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_request_gen import lsu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   valid_0_i,     // EX holds a load or store
  input  wire logic [`LSU_ADDR_W-1:0] operand_a_i,
  input  wire logic [`LSU_ADDR_W-1:0] operand_b_i,
  input  wire logic [`LSU_DATA_W-1:0] wdata_i,       // Store data, LSB aligned
  input  wire lsu_size_e              size_i,
  input  wire logic                   we_i,
  input  wire logic                   sext_i,
  input  wire logic                   ctrl_update_i, // EX address phase done
  lsu_obi_if.requester                bus,
  output logic                        split_0_o,     // First half of a split access
  output logic                        split_q_o,     // Second half of a split access
  output lsu_wb_ctrl_t                wb_ctrl_o
);

  logic [`LSU_ADDR_W-1:0]   addr;         // Sum of the operands
  logic [1:0]               offset;       // Byte offset within the word
  logic                     misaligned;   // Not naturally aligned
  logic                     split_q;
  logic [`LSU_BE_W-1:0]     be;
  logic [2*`LSU_DATA_W-1:0] wdata_dbl;    // Doubled store data for rotation

  assign addr   = operand_a_i + operand_b_i;
  assign offset = addr[1:0];

  //////////////////////////////////////////////////////////////////////
  // Split detection

  // Halfword at offset 1 stays in one word, offset 3 does not
  assign misaligned = ((size_i == LSU_WORD) && (offset != 2'b00)) ||
                      ((size_i == LSU_HALF) && offset[0]);

  assign split_0_o  = valid_0_i && !split_q && misaligned &&
                      ((size_i == LSU_WORD) || (offset == 2'b11));

  // Set while the second address phase is in EX
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;         // Killed or idle, next access starts fresh
    end else if (ctrl_update_i) begin
      split_q <= split_0_o;
    end
  end

  assign split_q_o = split_q;

  //////////////////////////////////////////////////////////////////////
  // Byte enables and write data

  always_comb begin
    be = '0;
    case (size_i)
      LSU_BYTE: be = 4'b0001 << offset;
      LSU_HALF: be = split_q ? 4'b0001 : (4'b0011 << offset); // Offset 3 leaves 1000
      default: begin
        // Second half takes the lanes the first half left over
        if (split_q) be = ~(4'b1111 << offset);
        else         be = 4'b1111 << offset;
      end
    endcase
  end

  // Rotate left by the byte offset so each byte meets its lane
  assign wdata_dbl = {wdata_i, wdata_i} << {offset, 3'b000};

  //////////////////////////////////////////////////////////////////////
  // Address phase fields

  always_comb begin
    bus.addr  = split_q ? {addr[`LSU_ADDR_W-1:2] + 1'b1, 2'b00} : addr; // Next word
    bus.we    = we_i;
    bus.be    = be;
    bus.wdata = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];
  end

  // Fields handed to WB with this transfer
  always_comb begin
    wb_ctrl_o.size   = size_i;
    wb_ctrl_o.sext   = sext_i;
    wb_ctrl_o.we     = we_i;
    wb_ctrl_o.offset = offset;
    wb_ctrl_o.last   = !split_0_o;  // First half of a split is not the last
  end

  // A raised request always carries at least one lane
  a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    bus.req |-> (bus.be != '0));

endmodule

`default_nettype wire

// File: hw/lsu_pipe_ctrl.sv
/*
  Pipeline control of the load/store unit
  Outstanding transaction counter and bus request strobe
  EX and WB valid/ready handshakes, control update pulse
  Busy and interruptible status
*/
`default_nettype none
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_pipe_ctrl import lsu_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  valid_0_i,
  input  wire logic  ready_0_i,
  input  wire logic  ready_1_i,
  input  wire logic  split_0_i,       // First half of split in EX
  lsu_obi_if.tracker bus,
  output logic       ready_0_o,
  output logic       valid_0_o,
  output logic       valid_1_o,
  output logic       ready_1_o,
  output logic       ctrl_update_o,   // EX address phase complete
  output logic       busy_o,
  output logic       interruptible_o
);

  localparam logic [`LSU_CNT_W-1:0] DEPTH = `LSU_DEPTH;

  logic [`LSU_CNT_W-1:0] cnt_q;       // Outstanding transfers
  logic                  cnt_avail;   // Room for another transfer
  logic                  count_up;
  logic                  count_down;
  logic                  addr_done;   // Address phase of this access finished
  logic                  done_0;
  logic                  req_held_q;  // Request up without completing

  //////////////////////////////////////////////////////////////////////
  // Outstanding transaction counter

  assign cnt_avail  = cnt_q < DEPTH;
  assign count_up   = bus.req && bus.gnt;
  assign count_down = bus.rvalid;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (count_up && !count_down) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (count_down && !count_up) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign bus.req = valid_0_i && cnt_avail;  // Limit holds req low

  //////////////////////////////////////////////////////////////////////
  // Handshakes

  // Full counter means WB is occupied, EX moves in lock step with it
  assign addr_done     = cnt_avail ? count_up : 1'b1;
  assign done_0        = (!valid_0_i || addr_done) && ready_0_i;
  assign valid_0_o     = addr_done && valid_0_i;
  assign ready_0_o     = done_0 && !split_0_i;   // Hold EX for second half
  assign ctrl_update_o = done_0 && valid_0_i;

  assign valid_1_o = bus.rvalid;                 // Once per transfer
  assign ready_1_o = ((cnt_q == '0) || bus.rvalid) && ready_1_i;

  // A request kept up across a clock may not be withdrawn
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      req_held_q <= 1'b0;
    end else if (ctrl_update_o) begin
      req_held_q <= 1'b0;
    end else if (bus.req) begin
      req_held_q <= 1'b1;
    end
  end

  assign interruptible_o = !req_held_q && (cnt_q == '0);
  assign busy_o          = (cnt_q != '0) || bus.req;

  // Counter stays within 0..DEPTH, rvalid only for a granted transfer
  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= DEPTH);
  a_cnt_min: assert property (@(posedge clk) disable iff (!rst_n)
    bus.rvalid |-> (cnt_q != '0));

endmodule

`default_nettype wire

// File: hw/lsu_rdata_align.sv
/*
  Load data path of the load/store unit
  WB control registers, held first half of a split load
  Realignment over two words, sign or zero extension by size
*/
`default_nettype none
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_rdata_align import lsu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   ctrl_update_i,
  input  wire lsu_wb_ctrl_t           wb_ctrl_i,
  input  wire logic                   split_0_i,
  input  wire logic                   split_q_i,
  lsu_obi_if.receiver                 bus,
  output logic [`LSU_DATA_W-1:0]      rdata_1_o
);

  lsu_wb_ctrl_t               wb_q;          // Control of the transfer in WB
  logic [`LSU_DATA_W-1:0]     rdata_q;       // Raw first half or last result
  logic                       hold_raw;      // Response belongs to first half
  logic                       rdata_is_split;
  logic [2*`LSU_DATA_W-1:0]   rdata_full;
  logic [2*`LSU_DATA_W-1:0]   rdata_aligned; // Upper word unused
  logic [`LSU_DATA_W-1:0]     rdata_ext;

  // Taken over when the address phase completes
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (ctrl_update_i) begin
      wb_q <= wb_ctrl_i;
    end
  end

  // First half returns while EX is on the second address phase
  assign hold_raw = split_q_i || split_0_i;

  always_ff @(posedge clk) begin
    if (bus.rvalid && !wb_q.we) begin
      rdata_q <= hold_raw ? bus.rdata : rdata_ext;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Realign and extend

  assign rdata_is_split = ((wb_q.size == LSU_WORD) && (wb_q.offset != 2'b00)) ||
                          ((wb_q.size == LSU_HALF) && (wb_q.offset == 2'b11));

  // Low bytes of a split come from the held word
  assign rdata_full    = rdata_is_split ? {bus.rdata, rdata_q} : {bus.rdata, bus.rdata};
  assign rdata_aligned = rdata_full >> {wb_q.offset, 3'b000};

  always_comb begin
    case (wb_q.size)
      LSU_BYTE: rdata_ext = {{24{wb_q.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      LSU_HALF: rdata_ext = {{16{wb_q.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:  rdata_ext = rdata_aligned[`LSU_DATA_W-1:0];
    endcase
  end

  assign rdata_1_o = rdata_ext;  // Meaningful on the last rvalid of a load

  // A response marked not last must be the first half being captured
  a_first_half: assert property (@(posedge clk) disable iff (!rst_n)
    (bus.rvalid && !wb_q.last) |-> hold_raw);

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
/*
  Top level of the load/store unit
  Plain EX, WB, status and data bus ports
  Internal bus interface, request generation, pipeline control, load data path
*/
`default_nettype none
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // EX stage
  input  wire logic                   valid_0_i,
  output logic                        ready_0_o,
  input  wire logic                   ready_0_i,
  output logic                        valid_0_o,
  input  wire logic [`LSU_ADDR_W-1:0] operand_a_i,
  input  wire logic [`LSU_ADDR_W-1:0] operand_b_i,
  input  wire logic [`LSU_DATA_W-1:0] wdata_i,
  input  wire lsu_size_e              size_i,
  input  wire logic                   we_i,
  input  wire logic                   sext_i,
  output logic                        split_0_o,
  output logic                        first_op_0_o,
  output logic                        last_op_0_o,
  // WB stage
  output logic                        valid_1_o,
  input  wire logic                   ready_1_i,
  output logic                        ready_1_o,
  output logic [`LSU_DATA_W-1:0]      rdata_1_o,
  // Status
  output logic                        busy_o,
  output logic                        interruptible_o,
  // Data bus
  output logic                        data_req_o,
  input  wire logic                   data_gnt_i,
  output logic [`LSU_ADDR_W-1:0]      data_addr_o,
  output logic                        data_we_o,
  output logic [`LSU_BE_W-1:0]        data_be_o,
  output logic [`LSU_DATA_W-1:0]      data_wdata_o,
  input  wire logic                   data_rvalid_i,
  input  wire logic [`LSU_DATA_W-1:0] data_rdata_i
);

  logic         ctrl_update;
  logic         split_0;
  logic         split_q;
  lsu_wb_ctrl_t wb_ctrl;

  lsu_obi_if obi ();

  // Bus to and from the pins
  assign data_req_o   = obi.req;
  assign data_addr_o  = obi.addr;
  assign data_we_o    = obi.we;
  assign data_be_o    = obi.be;
  assign data_wdata_o = obi.wdata;
  assign obi.gnt      = data_gnt_i;
  assign obi.rvalid   = data_rvalid_i;
  assign obi.rdata    = data_rdata_i;

  assign split_0_o    = split_0;
  assign first_op_0_o = !split_q;   // Not on the second half
  assign last_op_0_o  = !split_0;   // Not on the first half

  lsu_request_gen u_request_gen (
    .clk, .rst_n, .valid_0_i, .operand_a_i, .operand_b_i, .wdata_i, .size_i, .we_i, .sext_i,
    .ctrl_update_i (ctrl_update), .bus (obi.requester),
    .split_0_o (split_0), .split_q_o (split_q), .wb_ctrl_o (wb_ctrl)
  );

  lsu_pipe_ctrl u_pipe_ctrl (
    .clk, .rst_n, .valid_0_i, .ready_0_i, .ready_1_i, .split_0_i (split_0),
    .bus (obi.tracker), .ready_0_o, .valid_0_o, .valid_1_o, .ready_1_o,
    .ctrl_update_o (ctrl_update), .busy_o, .interruptible_o
  );

  lsu_rdata_align u_rdata_align (
    .clk, .rst_n, .ctrl_update_i (ctrl_update), .wb_ctrl_i (wb_ctrl),
    .split_0_i (split_0), .split_q_i (split_q), .bus (obi.receiver), .rdata_1_o
  );

endmodule

`default_nettype wire

// File: tests/lsu_mem_model.sv
/*
  Data memory responder for the load/store unit testbench
  Random grant stalls, rvalid one cycle after each grant
  Byte-enabled writes, word reads
*/
`default_nettype none
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_mem_model #(
  parameter int SEED = 87485
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   req_i,
  output logic                        gnt_o,
  input  wire logic [`LSU_ADDR_W-1:0] addr_i,
  input  wire logic                   we_i,
  input  wire logic [`LSU_BE_W-1:0]   be_i,
  input  wire logic [`LSU_DATA_W-1:0] wdata_i,
  output logic                        rvalid_o,
  output logic [`LSU_DATA_W-1:0]      rdata_o
);

  logic [`LSU_DATA_W-1:0] mem [0:255];   // 1 KiB, word indexed
  logic [31:0]            rnd;
  integer                 seed;

  // Fill depends on every bit of the word index
  initial begin
    seed = SEED;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0] ^ 8'hA5, ~i[7:0], i[7:0], i[7:0] ^ 8'h5A};
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Grant stalls and response

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rnd      = $random(seed);
      gnt_o    <= (rnd[1:0] != 2'b00);       // Stall about one cycle in four
      rvalid_o <= req_i && gnt_o;             // One response per transfer
      if (req_i && gnt_o) begin
        rdata_o <= mem[addr_i[9:2]];          // Read before this cycle's write
        if (we_i) begin
          for (int k = 0; k < `LSU_BE_W; k++) begin
            if (be_i[k]) mem[addr_i[9:2]][8*k +: 8] <= wdata_i[8*k +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_lsu.sv
/*
  Testbench of the load/store unit
  Clock, reset, table of accesses applied in a loop
  Bus phase, split, stall, load data and status checks
*/
`default_nettype none
`timescale 1ns/1ns
`include "lsu_defs.svh"

module tb_lsu import lsu_pkg::*; ();

  localparam logic [1:0] SZ_B = 2'd0;
  localparam logic [1:0] SZ_H = 2'd1;
  localparam logic [1:0] SZ_W = 2'd2;
  localparam int         MAX_CYCLES = 200;   // Per access

  typedef struct packed {
    logic [1:0]  size;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        we;
    logic        sext;
    logic [31:0] wdata;
    logic [31:0] exp_val;   // Load result, unused for stores
  } access_t;

  logic clk, rst_n, valid_0_i, ready_0_i, ready_1_i, we_i, sext_i;
  logic [31:0] operand_a_i, operand_b_i, wdata_i;
  lsu_size_e   size_i;
  logic ready_0_o, valid_0_o, split_0_o, first_op_0_o, last_op_0_o;
  logic valid_1_o, ready_1_o, busy_o, interruptible_o;
  logic [31:0] rdata_1_o, data_addr_o, data_wdata_o, data_rdata_i;
  logic data_req_o, data_gnt_i, data_we_o, data_rvalid_i;
  logic [3:0]  data_be_o;

  access_t tbl [$];
  string   tbl_name [$];

  lsu_top UUT (.*);

  lsu_mem_model u_mem (
    .clk, .rst_n, .req_i (data_req_o), .gnt_o (data_gnt_i), .addr_i (data_addr_o),
    .we_i (data_we_o), .be_i (data_be_o), .wdata_i (data_wdata_o),
    .rvalid_o (data_rvalid_i), .rdata_o (data_rdata_i)
  );

  always #2 clk = ~clk;   // 4 ns period

  ////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else
      stop_with_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic add_access(input string name, input logic [1:0] sz, input logic [31:0] a,
                            input logic [31:0] b, input logic we, input logic sext,
                            input logic [31:0] wd, input logic [31:0] exp_val);
    tbl.push_back(access_t'{sz, a, b, we, sext, wd, exp_val});
    tbl_name.push_back(name);
  endtask

  // One access from EX issue to final response, then status check
  task automatic run_access(input int idx);
    access_t     acc;
    string       n;
    logic [31:0] addr, prev_addr, load_val;
    logic [7:0]  mask;   // Byte lanes over this word and the next
    logic [3:0]  prev_be;
    logic        ex_done, stalled;
    int          exp_xfers, grants, resps, cycles;
    acc  = tbl[idx];
    n    = tbl_name[idx];
    addr = acc.op_a + acc.op_b;
    mask = (acc.size == SZ_W) ? 8'h0F : (acc.size == SZ_H) ? 8'h03 : 8'h01;
    mask = mask << addr[1:0];
    exp_xfers = (mask[7:4] != 4'h0) ? 2 : 1;
    grants = 0;
    resps = 0;
    cycles = 0;
    ex_done = 1'b0;
    stalled = 1'b0;
    prev_addr = '0;
    prev_be = '0;
    load_val = '0;
    @(negedge clk);
    operand_a_i = acc.op_a;
    operand_b_i = acc.op_b;
    size_i      = lsu_size_e'(acc.size);
    we_i        = acc.we;
    sext_i      = acc.sext;
    wdata_i     = acc.wdata;
    valid_0_i   = 1'b1;
    while (!ex_done || resps < grants) begin
      #1;  // Sample mid low phase
      // Status from what is outstanding before this cycle
      check_value({n, " busy"}, 32'((grants != resps) || valid_0_i), 32'(busy_o));
      check_value({n, " interruptible"}, 32'((grants == resps) && !stalled),
                  32'(interruptible_o));
      check_value({n, " ready_1"}, 32'((grants == resps) || data_rvalid_i), 32'(ready_1_o));
      if (valid_1_o) begin
        resps++;
        if (resps == exp_xfers) load_val = rdata_1_o;
      end
      if (valid_0_i) begin
        check_value({n, " req"}, 32'd1, 32'(data_req_o));
        if (stalled) begin
          check_value({n, " addr held"}, prev_addr, data_addr_o);
          check_value({n, " be held"}, 32'(prev_be), 32'(data_be_o));
        end
        if (data_gnt_i) begin
          grants++;
          stalled = 1'b0;
          check_value({n, " valid_0"}, 32'd1, 32'(valid_0_o));
          check_value({n, " we"}, 32'(acc.we), 32'(data_we_o));
          check_value({n, " first_op"}, 32'(grants == 1), 32'(first_op_0_o));
          check_value({n, " last_op"}, 32'(grants == exp_xfers), 32'(last_op_0_o));
          if (grants == 1) begin
            check_value({n, " addr"}, addr, data_addr_o);
            check_value({n, " be"}, 32'(mask[3:0]), 32'(data_be_o));
            check_value({n, " split_0"}, 32'(exp_xfers == 2), 32'(split_0_o));
          end else begin
            check_value({n, " addr 2nd"}, {addr[31:2] + 30'd1, 2'b00}, data_addr_o);
            check_value({n, " be 2nd"}, 32'(mask[7:4]), 32'(data_be_o));
          end
          check_value({n, " ready_0"}, 32'(grants == exp_xfers), 32'(ready_0_o));
          ex_done = (grants == exp_xfers);
        end else begin
          check_value({n, " ready_0 stalled"}, 32'd0, 32'(ready_0_o));
          check_value({n, " valid_0 stalled"}, 32'd0, 32'(valid_0_o));
          stalled   = 1'b1;
          prev_addr = data_addr_o;
          prev_be   = data_be_o;
        end
      end
      cycles++;
      if (cycles > MAX_CYCLES) stop_with_error({"Timeout: access ", n, " did not complete"});
      @(negedge clk);
      if (ex_done) valid_0_i = 1'b0;   // Release EX after the last grant
    end
    check_value({n, " responses"}, 32'(exp_xfers), 32'(resps));
    if (!acc.we) check_value({n, " load data"}, acc.exp_val, load_val);
    #1;
    check_value({n, " busy after"}, 32'd0, 32'(busy_o));
    check_value({n, " interruptible after"}, 32'd1, 32'(interruptible_o));
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    valid_0_i = 1'b0;
    ready_0_i = 1'b1;
    ready_1_i = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    wdata_i = '0;
    size_i = LSU_BYTE;
    we_i = 1'b0;
    sext_i = 1'b0;

    //         name            size  op_a        op_b          we    sext  wdata         expected
    add_access("sw aligned",   SZ_W, 32'h100, 32'h0,         1'b1, 1'b0, 32'h12345678, 32'h0);
    add_access("lw aligned",   SZ_W, 32'h100, 32'h0,         1'b0, 1'b0, 32'h0, 32'h12345678);
    add_access("sw base",      SZ_W, 32'h104, 32'h0,         1'b1, 1'b0, 32'h11223344, 32'h0);
    add_access("sb lane1",     SZ_B, 32'h104, 32'h1,         1'b1, 1'b0, 32'hFFFFFFAB, 32'h0);
    add_access("lb sext",      SZ_B, 32'h104, 32'h1,         1'b0, 1'b1, 32'h0, 32'hFFFFFFAB);
    add_access("lbu",          SZ_B, 32'h104, 32'h1,         1'b0, 1'b0, 32'h0, 32'h000000AB);
    add_access("sh upper",     SZ_H, 32'h104, 32'h2,         1'b1, 1'b0, 32'h00008001, 32'h0);
    add_access("lh sext",      SZ_H, 32'h104, 32'h2,         1'b0, 1'b1, 32'h0, 32'hFFFF8001);
    add_access("lhu",          SZ_H, 32'h104, 32'h2,         1'b0, 1'b0, 32'h0, 32'h00008001);
    add_access("lh off1",      SZ_H, 32'h104, 32'h1,         1'b0, 1'b1, 32'h0, 32'h000001AB);
    add_access("sh off1",      SZ_H, 32'h108, 32'h1,         1'b1, 1'b0, 32'h0000BEEF, 32'h0);
    add_access("lhu off1",     SZ_H, 32'h108, 32'h1,         1'b0, 1'b0, 32'h0, 32'h0000BEEF);
    add_access("sw off3",      SZ_W, 32'h108, 32'h3,         1'b1, 1'b0, 32'hCAFEF00D, 32'h0);
    add_access("lw off3",      SZ_W, 32'h108, 32'h3,         1'b0, 1'b0, 32'h0, 32'hCAFEF00D);
    add_access("sw off1",      SZ_W, 32'h110, 32'h1,         1'b1, 1'b0, 32'hA1B2C3D4, 32'h0);
    add_access("lw off1",      SZ_W, 32'h110, 32'h1,         1'b0, 1'b0, 32'h0, 32'hA1B2C3D4);
    add_access("sw off2 neg",  SZ_W, 32'h120, 32'hFFFFFFF6,  1'b1, 1'b0, 32'h0BADCAFE, 32'h0);
    add_access("lw off2 neg",  SZ_W, 32'h120, 32'hFFFFFFF6,  1'b0, 1'b0, 32'h0, 32'h0BADCAFE);
    add_access("sh off3",      SZ_H, 32'h118, 32'h3,         1'b1, 1'b0, 32'h00009876, 32'h0);
    add_access("lh off3 sext", SZ_H, 32'h118, 32'h3,         1'b0, 1'b1, 32'h0, 32'hFFFF9876);
    add_access("lhu off3",     SZ_H, 32'h118, 32'h3,         1'b0, 1'b0, 32'h0, 32'h00009876);
    add_access("lb split tail", SZ_B, 32'h10C, 32'h0,        1'b0, 1'b1, 32'h0, 32'hFFFFFFF0);
    add_access("lw merged",    SZ_W, 32'h104, 32'h0,         1'b0, 1'b0, 32'h0, 32'h8001AB44);

    // Reset for two cycles, release on falling edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value("reset data_req", 32'd0, 32'(data_req_o));
    check_value("reset valid_0", 32'd0, 32'(valid_0_o));
    check_value("reset valid_1", 32'd0, 32'(valid_1_o));
    check_value("reset busy", 32'd0, 32'(busy_o));
    check_value("reset interruptible", 32'd1, 32'(interruptible_o));

    for (int i = 0; i < tbl.size(); i++) begin
      run_access(i);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_obi_if.sv
hw/lsu_request_gen.sv
hw/lsu_pipe_ctrl.sv
hw/lsu_rdata_align.sv
hw/lsu_top.sv
tests/lsu_mem_model.sv
tests/tb_lsu.sv

// File: Makefile
# Verilator simulation of the load/store unit

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# Build, run, and succeed only if the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
